/* hw/alu_rs.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_rs
  import ooo_pkg::*;
#(
  parameter int ALU_RS_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  dispatch_t                 dispatch,
  input  cdb_lane_t [CDB_LANES-1:0] cdb,
  output logic                      full,
  output cdb_lane_t                 lane
);

  localparam int IDX_W = (ALU_RS_DEPTH > 1) ? $clog2(ALU_RS_DEPTH) : 1;

  dispatch_t               slots      [ALU_RS_DEPTH];
  dispatch_t               woken      [ALU_RS_DEPTH];
  dispatch_t               slots_next [ALU_RS_DEPTH];
  logic [ALU_RS_DEPTH-1:0] valid;
  logic [ALU_RS_DEPTH-1:0] valid_next;
  logic                    sel_valid;
  logic [IDX_W-1:0]        sel_idx;
  logic [IDX_W-1:0]        free_idx;
  dispatch_t               sel;
  word_t                   result;

  assign full = &valid;

  // wake-up, immediates never wait
  always_comb begin
    for (int i = 0; i < ALU_RS_DEPTH; i++) begin
      woken[i]   = slots[i];
      woken[i].a = cdb_snoop(slots[i].a, cdb);
      if (!slots[i].b_imm) begin
        woken[i].b = cdb_snoop(slots[i].b, cdb);
      end
    end
  end

  // entries stay packed by age, index 0 is the oldest
  always_comb begin
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int i = ALU_RS_DEPTH - 1; i >= 0; i--) begin
      if (valid[i] && slots[i].a.ready && slots[i].b.ready) begin
        sel_valid = 1'b1;
        sel_idx   = IDX_W'(i);
      end
    end
  end

  assign sel = slots[sel_idx];

  always_comb begin
    valid_next = valid;
    slots_next = woken;
    if (sel_valid) begin
      for (int i = 0; i < ALU_RS_DEPTH - 1; i++) begin
        if (IDX_W'(i) >= sel_idx) begin
          valid_next[i] = valid[i+1];
          slots_next[i] = woken[i+1];
        end
      end
      valid_next[ALU_RS_DEPTH-1] = 1'b0;
    end
    free_idx = '0;
    for (int i = ALU_RS_DEPTH - 1; i >= 0; i--) begin
      if (!valid_next[i]) begin
        free_idx = IDX_W'(i);
      end
    end
    if (push) begin
      slots_next[free_idx] = dispatch;
      valid_next[free_idx] = 1'b1;
    end
  end

  always_comb begin
    case (sel.op)
      ALU_ADD:  result = sel.a.value + sel.b.value;
      ALU_SUB:  result = sel.a.value - sel.b.value;
      ALU_SLL:  result = sel.a.value << sel.b.value[4:0];
      ALU_SLT:  result = {31'b0, $signed(sel.a.value) < $signed(sel.b.value)};
      ALU_SLTU: result = {31'b0, sel.a.value < sel.b.value};
      ALU_XOR:  result = sel.a.value ^ sel.b.value;
      ALU_SRL:  result = sel.a.value >> sel.b.value[4:0];
      ALU_SRA:  result = word_t'($signed(sel.a.value) >>> sel.b.value[4:0]);
      ALU_OR:   result = sel.a.value | sel.b.value;
      default:  result = sel.a.value & sel.b.value;
    endcase
  end

  always_ff @(posedge clk) begin
    slots      <= slots_next;
    lane.tag   <= sel.tag;
    lane.value <= result;
    if (rst) begin
      valid      <= '0;
      lane.valid <= 1'b0;
    end else begin
      valid      <= valid_next;
      lane.valid <= sel_valid;
    end
  end

endmodule

`default_nettype wire

/* hw/issue_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_unit
  import ooo_pkg::*;
(
  input  logic                      instr_valid,
  input  word_t                     instr,
  output logic                      instr_ready,
  output reg_idx_t                  rs1,
  output reg_idx_t                  rs2,
  output reg_idx_t                  rd,
  input  operand_t                  sb_op_a,
  input  operand_t                  sb_op_b,
  input  operand_t                  rob_op_a,
  input  operand_t                  rob_op_b,
  input  cdb_lane_t [CDB_LANES-1:0] cdb,
  input  logic                      alu_full,
  input  logic                      mul_full,
  input  logic                      rob_full,
  input  rob_tag_t                  alloc_tag,
  output logic                      alu_push,
  output logic                      mul_push,
  output logic                      rob_push,
  output dispatch_t                 dispatch
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_lui;
  logic       is_imm;
  logic       is_mul;
  word_t      imm;
  alu_op_e    op;
  operand_t   op_a;
  operand_t   op_b;

  // scoreboard first, then a finished rob entry, then this cycle's broadcast
  function automatic operand_t resolve(operand_t sb, operand_t from_rob,
                                       cdb_lane_t [CDB_LANES-1:0] lanes);
    if (sb.ready) begin
      return sb;
    end
    if (from_rob.ready) begin
      return from_rob;
    end
    return cdb_snoop(sb, lanes);
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign is_lui = opcode == OPC_LUI;
  assign is_imm = opcode == OPC_OP_IMM || is_lui;
  // funct7 0000001 selects mul
  assign is_mul = opcode == OPC_OP && instr[25];
  assign imm    = is_lui ? {instr[31:12], 12'b0} : {{20{instr[31]}}, instr[31:20]};

  always_comb begin
    case (funct3)
      3'b000:  op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    // lui is imm + 0
    if (is_lui) begin
      op = ALU_ADD;
    end
  end

  assign op_a = is_lui ? '{ready: 1'b1, value: '0, tag: '0}
                       : resolve(sb_op_a, rob_op_a, cdb);
  assign op_b = is_imm ? '{ready: 1'b1, value: imm, tag: '0}
                       : resolve(sb_op_b, rob_op_b, cdb);

  assign instr_ready = (is_mul ? !mul_full : !alu_full) && !rob_full;
  assign rob_push    = instr_valid && instr_ready;
  assign alu_push    = rob_push && !is_mul;
  assign mul_push    = rob_push && is_mul;

  assign dispatch = '{tag: alloc_tag, op: op, a: op_a, b: op_b, b_imm: is_imm};

endmodule

`default_nettype wire

/* hw/mul_rs.sv */
`timescale 1ns/100ps
`default_nettype none

module mul_rs
  import ooo_pkg::*;
#(
  parameter int MUL_RS_DEPTH = 2,
  parameter int MUL_STAGES   = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  dispatch_t                 dispatch,
  input  cdb_lane_t [CDB_LANES-1:0] cdb,
  output logic                      full,
  output cdb_lane_t                 lane
);

  localparam int IDX_W = (MUL_RS_DEPTH > 1) ? $clog2(MUL_RS_DEPTH) : 1;

  dispatch_t               slots      [MUL_RS_DEPTH];
  dispatch_t               woken      [MUL_RS_DEPTH];
  dispatch_t               slots_next [MUL_RS_DEPTH];
  logic [MUL_RS_DEPTH-1:0] valid;
  logic [MUL_RS_DEPTH-1:0] valid_next;
  logic                    sel_valid;
  logic [IDX_W-1:0]        sel_idx;
  logic [IDX_W-1:0]        free_idx;
  dispatch_t               sel;
  word_t                   product;
  cdb_lane_t               pipe [MUL_STAGES];

  assign full = &valid;

  always_comb begin
    for (int i = 0; i < MUL_RS_DEPTH; i++) begin
      woken[i]   = slots[i];
      woken[i].a = cdb_snoop(slots[i].a, cdb);
      woken[i].b = cdb_snoop(slots[i].b, cdb);
    end
  end

  // oldest ready wins
  always_comb begin
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int i = MUL_RS_DEPTH - 1; i >= 0; i--) begin
      if (valid[i] && slots[i].a.ready && slots[i].b.ready) begin
        sel_valid = 1'b1;
        sel_idx   = IDX_W'(i);
      end
    end
  end

  assign sel = slots[sel_idx];

  always_comb begin
    valid_next = valid;
    slots_next = woken;
    if (sel_valid) begin
      for (int i = 0; i < MUL_RS_DEPTH - 1; i++) begin
        if (IDX_W'(i) >= sel_idx) begin
          valid_next[i] = valid[i+1];
          slots_next[i] = woken[i+1];
        end
      end
      valid_next[MUL_RS_DEPTH-1] = 1'b0;
    end
    free_idx = '0;
    for (int i = MUL_RS_DEPTH - 1; i >= 0; i--) begin
      if (!valid_next[i]) begin
        free_idx = IDX_W'(i);
      end
    end
    if (push) begin
      slots_next[free_idx] = dispatch;
      valid_next[free_idx] = 1'b1;
    end
  end

  // low half only
  assign product = sel.a.value * sel.b.value;

  always_ff @(posedge clk) begin
    slots         <= slots_next;
    pipe[0].tag   <= sel.tag;
    pipe[0].value <= product;
    for (int s = 1; s < MUL_STAGES; s++) begin
      pipe[s].tag   <= pipe[s-1].tag;
      pipe[s].value <= pipe[s-1].value;
    end
    if (rst) begin
      valid <= '0;
      for (int s = 0; s < MUL_STAGES; s++) begin
        pipe[s].valid <= 1'b0;
      end
    end else begin
      valid         <= valid_next;
      pipe[0].valid <= sel_valid;
      for (int s = 1; s < MUL_STAGES; s++) begin
        pipe[s].valid <= pipe[s-1].valid;
      end
    end
  end

  assign lane = pipe[MUL_STAGES-1];

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_core
  import ooo_pkg::*;
#(
  parameter int ALU_RS_DEPTH = 4,
  parameter int MUL_RS_DEPTH = 2,
  parameter int MUL_STAGES   = 3
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    instr_valid,
  input  word_t   instr,
  output logic    instr_ready,
  output logic    commit_valid,
  output commit_t commit
);

  reg_idx_t                    rs1;
  reg_idx_t                    rs2;
  reg_idx_t                    rd;
  operand_t                    sb_op_a;
  operand_t                    sb_op_b;
  operand_t                    rob_op_a;
  operand_t                    rob_op_b;
  cdb_lane_t [CDB_LANES-1:0]   cdb;
  logic                        alu_full;
  logic                        mul_full;
  logic                        rob_full;
  rob_tag_t                    alloc_tag;
  rob_tag_t                    commit_tag;
  logic                        alu_push;
  logic                        mul_push;
  logic                        rob_push;
  dispatch_t                   dispatch;

  issue_unit issue_unit (
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_ready(instr_ready),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .sb_op_a(sb_op_a),
    .sb_op_b(sb_op_b),
    .rob_op_a(rob_op_a),
    .rob_op_b(rob_op_b),
    .cdb(cdb),
    .alu_full(alu_full),
    .mul_full(mul_full),
    .rob_full(rob_full),
    .alloc_tag(alloc_tag),
    .alu_push(alu_push),
    .mul_push(mul_push),
    .rob_push(rob_push),
    .dispatch(dispatch)
  );

  regfile_scoreboard regfile_scoreboard (
    .clk(clk),
    .rst(rst),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .issue_push(rob_push),
    .alloc_tag(alloc_tag),
    .op_a(sb_op_a),
    .op_b(sb_op_b),
    .commit_valid(commit_valid),
    .commit(commit),
    .commit_tag(commit_tag)
  );

  alu_rs #(
    .ALU_RS_DEPTH(ALU_RS_DEPTH)
  ) alu_rs (
    .clk(clk),
    .rst(rst),
    .push(alu_push),
    .dispatch(dispatch),
    .cdb(cdb),
    .full(alu_full),
    .lane(cdb[0])
  );

  mul_rs #(
    .MUL_RS_DEPTH(MUL_RS_DEPTH),
    .MUL_STAGES(MUL_STAGES)
  ) mul_rs (
    .clk(clk),
    .rst(rst),
    .push(mul_push),
    .dispatch(dispatch),
    .cdb(cdb),
    .full(mul_full),
    .lane(cdb[1])
  );

  // pending tags from the scoreboard index the rob lookup
  rob rob (
    .clk(clk),
    .rst(rst),
    .push(rob_push),
    .rd(rd),
    .lookup_a(sb_op_a.tag),
    .lookup_b(sb_op_b.tag),
    .rob_op_a(rob_op_a),
    .rob_op_b(rob_op_b),
    .alloc_tag(alloc_tag),
    .full(rob_full),
    .cdb(cdb),
    .commit_valid(commit_valid),
    .commit(commit),
    .commit_tag(commit_tag)
  );

endmodule

`default_nettype wire

/* hw/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_W = 3;

  typedef logic [ROB_IDX_W-1:0] rob_tag_t;

  // value is only meaningful once ready is set
  typedef struct packed {
    logic     ready;
    word_t    value;
    rob_tag_t tag;
  } operand_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    rob_tag_t tag;
    alu_op_e  op;
    operand_t a;
    operand_t b;
    logic     b_imm;
  } dispatch_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    word_t    value;
  } cdb_lane_t;

  // lane 0 alu, lane 1 multiplier
  localparam int CDB_LANES = 2;

  typedef struct packed {
    reg_idx_t rd;
    word_t    value;
  } commit_t;

  // pick up a broadcast result for a waiting operand
  function automatic operand_t cdb_snoop(operand_t op, cdb_lane_t [CDB_LANES-1:0] lanes);
    operand_t res;
    res = op;
    for (int l = 0; l < CDB_LANES; l++) begin
      if (!op.ready && lanes[l].valid && lanes[l].tag == op.tag) begin
        res.ready = 1'b1;
        res.value = lanes[l].value;
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* hw/regfile_scoreboard.sv */
`timescale 1ns/100ps
`default_nettype none

module regfile_scoreboard
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     issue_push,
  input  rob_tag_t alloc_tag,
  output operand_t op_a,
  output operand_t op_b,
  input  logic     commit_valid,
  input  commit_t  commit,
  input  rob_tag_t commit_tag
);

  word_t       regs [32];
  rob_tag_t    tags [32];
  logic [31:0] busy;
  logic        commit_hit;

  // x0 is never marked busy and never written, so it reads as ready zero
  assign op_a = '{ready: !busy[rs1], value: regs[rs1], tag: tags[rs1]};
  assign op_b = '{ready: !busy[rs2], value: regs[rs2], tag: tags[rs2]};

  // only the youngest producer of rd may retire into it
  assign commit_hit = commit_valid && commit.rd != '0 && busy[commit.rd]
                      && tags[commit.rd] == commit_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit_hit) begin
        regs[commit.rd] <= commit.value;
        busy[commit.rd] <= 1'b0;
      end
      // a new issue to the same register overrides the clear above
      if (issue_push && rd != '0) begin
        busy[rd] <= 1'b1;
        tags[rd] <= alloc_tag;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rob.sv */
`timescale 1ns/100ps
`default_nettype none

module rob
  import ooo_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  reg_idx_t                  rd,
  input  rob_tag_t                  lookup_a,
  input  rob_tag_t                  lookup_b,
  output operand_t                  rob_op_a,
  output operand_t                  rob_op_b,
  output rob_tag_t                  alloc_tag,
  output logic                      full,
  input  cdb_lane_t [CDB_LANES-1:0] cdb,
  output logic                      commit_valid,
  output commit_t                   commit,
  output rob_tag_t                  commit_tag
);

  localparam logic [ROB_IDX_W:0] COUNT_MAX = (ROB_IDX_W + 1)'(ROB_DEPTH);
  localparam logic [ROB_IDX_W:0] COUNT_ONE = (ROB_IDX_W + 1)'(1);

  reg_idx_t             rd_q    [ROB_DEPTH];
  word_t                value_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done;
  rob_tag_t             head;
  rob_tag_t             tail;
  logic [ROB_IDX_W:0]   count;
  logic [ROB_IDX_W:0]   count_next;
  logic                 pop;

  assign alloc_tag = tail;

  // head retires once its result has landed
  assign pop          = count != '0 && done[head];
  assign commit_valid = pop;
  assign commit       = '{rd: rd_q[head], value: value_q[head]};
  assign commit_tag   = head;

  assign rob_op_a = '{ready: done[lookup_a], value: value_q[lookup_a], tag: lookup_a};
  assign rob_op_b = '{ready: done[lookup_b], value: value_q[lookup_b], tag: lookup_b};

  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + COUNT_ONE;
      2'b01:   count_next = count - COUNT_ONE;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < CDB_LANES; l++) begin
      if (cdb[l].valid) begin
        value_q[cdb[l].tag] <= cdb[l].value;
      end
    end
    if (push) begin
      rd_q[tail] <= rd;
    end
    if (rst) begin
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
      // reads full while in reset so issue stays stalled
      full  <= 1'b1;
    end else begin
      for (int l = 0; l < CDB_LANES; l++) begin
        if (cdb[l].valid) begin
          done[cdb[l].tag] <= 1'b1;
        end
      end
      if (push) begin
        done[tail] <= 1'b0;
        tail       <= tail + rob_tag_t'(1);
      end
      if (pop) begin
        head <= head + rob_tag_t'(1);
      end
      count <= count_next;
      full  <= count_next == COUNT_MAX;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_ooo_core -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ooo_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* verification/tb_ooo_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core
  import ooo_pkg::*;
();

  localparam int NUM_RANDOM       = 200;
  localparam int RESET_CYCLES     = 5;
  localparam int CYCLES_PER_INSTR = 40;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic    clk;
  logic    rst;
  logic    instr_valid;
  word_t   instr;
  logic    instr_ready;
  logic    commit_valid;
  commit_t commit;

  string       tbl_name [$];
  word_t       tbl_instr [$];
  word_t       tbl_expect [$];
  string       exp_name [$];
  commit_t     exp_commit [$];
  word_t       model_regs [32];
  logic [31:0] seed;
  int          errors = 0;
  int          stall_cycles = 0;
  int          cycle_count = 0;
  int          cycle_limit;
  string       got_name;
  commit_t     want;

  tb_clock_gen clock_gen (
    .clk(clk)
  );

  ooo_core dut0 (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_ready(instr_ready),
    .commit_valid(commit_valid),
    .commit(commit)
  );

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // rv32i result of one word against the model register file
  function automatic word_t model_exec(input word_t w);
    logic [6:0] opc;
    word_t      a;
    word_t      b;
    word_t      res;
    opc = w[6:0];
    a   = model_regs[w[19:15]];
    b   = (opc == OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
    case (w[14:12])
      3'd0:    res = (opc == OPC_OP && w[30]) ? a - b : a + b;
      3'd1:    res = a << b[4:0];
      3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    res = (a < b) ? 32'd1 : 32'd0;
      3'd4:    res = a ^ b;
      3'd5:    res = w[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
    if (opc == OPC_OP && w[25]) begin
      res = a * b;
    end
    if (opc == OPC_LUI) begin
      res = {w[31:12], 12'b0};
    end
    return res;
  endfunction

  // small register range on purpose, to get plenty of hazards
  function automatic word_t random_instr(input logic [31:0] r1, input logic [31:0] r2);
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    word_t       w;
    rd  = reg_idx_t'(r1[28:26]);
    rs1 = reg_idx_t'(r1[25:23]);
    rs2 = reg_idx_t'(r1[22:20]);
    f3  = r1[19:17];
    alt = r1[16];
    imm = r2[31:20];
    case (r1[31:29])
      3'd0, 3'd1, 3'd2: begin
        w = r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
      end
      3'd3, 3'd4, 3'd5: begin
        if (f3 == 3'd1) begin
          imm = {7'h00, r2[24:20]};
        end else if (f3 == 3'd5) begin
          imm = {alt ? 7'h20 : 7'h00, r2[24:20]};
        end
        w = i_type(imm, rs1, f3, rd);
      end
      3'd6:    w = r_type(7'h01, rs2, rs1, 3'd0, rd);
      default: w = u_type(r2[31:12], rd);
    endcase
    return w;
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      errors++;
      fail_stop($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic add_entry(input string name, input word_t w, input word_t value);
    tbl_name.push_back(name);
    tbl_instr.push_back(w);
    tbl_expect.push_back(value);
  endtask

  task automatic expect_commit(input string name, input word_t w, input word_t value);
    commit_t c;
    c.rd    = w[11:7];
    c.value = value;
    exp_name.push_back(name);
    exp_commit.push_back(c);
    if (w[11:7] != 5'd0) begin
      model_regs[w[11:7]] = value;
    end
  endtask

  // holds the word until the handshake edge
  task automatic send_instr(input string name, input word_t w, input word_t value);
    @(negedge clk);
    expect_commit(name, w, value);
    instr_valid = 1'b1;
    instr       = w;
    @(posedge clk);
    while (!instr_ready) begin
      stall_cycles++;
      @(posedge clk);
    end
  endtask

  task automatic build_table();
    add_entry("addi pos", i_type(12'd100, 5'd0, 3'd0, 5'd1), 32'h00000064);
    add_entry("addi neg", i_type(12'hff9, 5'd0, 3'd0, 5'd2), 32'hfffffff9);
    add_entry("addi three", i_type(12'd3, 5'd0, 3'd0, 5'd3), 32'h00000003);
    add_entry("sra", r_type(7'h20, 5'd3, 5'd2, 3'd5, 5'd4), 32'hffffffff);
    add_entry("sltu", r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd5), 32'h00000001);
    add_entry("slt", r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd6), 32'h00000001);
    add_entry("xori", i_type(12'hfff, 5'd1, 3'd4, 5'd7), 32'hffffff9b);
    add_entry("andi", i_type(12'h0ff, 5'd2, 3'd7, 5'd8), 32'h000000f9);
    add_entry("ori", i_type(12'h700, 5'd1, 3'd6, 5'd9), 32'h00000764);
    add_entry("slli", i_type(12'h004, 5'd3, 3'd1, 5'd10), 32'h00000030);
    add_entry("srli", i_type(12'h01c, 5'd2, 3'd5, 5'd11), 32'h0000000f);
    add_entry("srai", i_type(12'h401, 5'd2, 3'd5, 5'd12), 32'hfffffffc);
    add_entry("sub", r_type(7'h20, 5'd3, 5'd1, 3'd0, 5'd13), 32'h00000061);
    add_entry("and", r_type(7'h00, 5'd1, 5'd2, 3'd7, 5'd17), 32'h00000060);
    add_entry("chain 1", i_type(12'd5, 5'd0, 3'd0, 5'd21), 32'h00000005);
    add_entry("chain 2", r_type(7'h00, 5'd21, 5'd21, 3'd0, 5'd21), 32'h0000000a);
    add_entry("chain 3", r_type(7'h00, 5'd21, 5'd21, 3'd0, 5'd21), 32'h00000014);
    add_entry("chain 4", r_type(7'h20, 5'd1, 5'd21, 3'd0, 5'd22), 32'hffffffb0);
    add_entry("chain 5", i_type(12'h050, 5'd22, 3'd0, 5'd22), 32'h00000000);
    add_entry("mul first", r_type(7'h01, 5'd1, 5'd1, 3'd0, 5'd23), 32'h00002710);
    add_entry("alu after mul 1", i_type(12'd1, 5'd0, 3'd0, 5'd24), 32'h00000001);
    add_entry("alu after mul 2", i_type(12'd2, 5'd0, 3'd0, 5'd25), 32'h00000002);
    add_entry("alu after mul 3", r_type(7'h00, 5'd25, 5'd24, 3'd0, 5'd26), 32'h00000003);
    add_entry("uses mul", r_type(7'h00, 5'd24, 5'd23, 3'd0, 5'd27), 32'h00002711);
    add_entry("mul burst 1", r_type(7'h01, 5'd3, 5'd3, 3'd0, 5'd28), 32'h00000009);
    add_entry("mul burst 2", r_type(7'h01, 5'd3, 5'd28, 3'd0, 5'd28), 32'h0000001b);
    add_entry("mul burst 3", r_type(7'h01, 5'd3, 5'd28, 3'd0, 5'd28), 32'h00000051);
    add_entry("mul burst 4", r_type(7'h01, 5'd3, 5'd28, 3'd0, 5'd28), 32'h000000f3);
    add_entry("mul burst 5", r_type(7'h01, 5'd3, 5'd28, 3'd0, 5'd28), 32'h000002d9);
    add_entry("mul burst 6", r_type(7'h01, 5'd3, 5'd28, 3'd0, 5'd28), 32'h0000088b);
    add_entry("mul burst 7", r_type(7'h01, 5'd3, 5'd28, 3'd0, 5'd28), 32'h000019a1);
    add_entry("mul burst 8", r_type(7'h01, 5'd3, 5'd28, 3'd0, 5'd28), 32'h00004ce3);
    add_entry("mul negative", r_type(7'h01, 5'd1, 5'd2, 3'd0, 5'd29), 32'hfffffd44);
    add_entry("x0 write", i_type(12'd5, 5'd1, 3'd0, 5'd0), 32'h00000069);
    add_entry("x0 read", r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd30), 32'h00000064);
    add_entry("lui", u_type(20'h12345, 5'd31), 32'h12345000);
    add_entry("lui x0", u_type(20'habcde, 5'd0), 32'habcde000);
    add_entry("x0 after lui", i_type(12'd1, 5'd0, 3'd0, 5'd30), 32'h00000001);
  endtask

  // in-order commit check against the queue of expected results
  always @(posedge clk) begin
    if (!rst && commit_valid) begin
      if (exp_commit.size() == 0) begin
        fail_stop("a commit arrived with no instruction outstanding");
      end else begin
        got_name = exp_name.pop_front();
        want     = exp_commit.pop_front();
        check_value({got_name, " rd"}, word_t'(want.rd), word_t'(commit.rd));
        check_value(got_name, want.value, commit.value);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      fail_stop($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin : stimulus
    word_t       w;
    word_t       v;
    logic [31:0] r1;
    logic [31:0] r2;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    seed        = 32'h87dc;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    build_table();
    cycle_limit = CYCLES_PER_INSTR * (tbl_instr.size() + NUM_RANDOM) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < tbl_instr.size(); i++) begin
      if (tbl_name[i] == "mul burst 1") begin
        stall_cycles = 0;
      end
      // the burst must have backed up into the issue port
      if (tbl_name[i] == "x0 write" && stall_cycles == 0) begin
        fail_stop("instr_ready never dropped during the multiply burst");
      end
      send_instr(tbl_name[i], tbl_instr[i], tbl_expect[i]);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      seed = lcg_next(seed);
      r1   = seed;
      seed = lcg_next(seed);
      r2   = seed;
      w    = random_instr(r1, r2);
      v    = model_exec(w);
      send_instr($sformatf("random %0d", i), w, v);
    end

    @(negedge clk);
    instr_valid = 1'b0;
    while (exp_commit.size() != 0) begin
      @(posedge clk);
    end
    // a few idle cycles to catch stray commits
    repeat (10) @(negedge clk);

    if (errors == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      fail_stop($sformatf("%0d checks failed", errors));
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/ooo_pkg.sv
hw/issue_unit.sv
hw/regfile_scoreboard.sv
hw/alu_rs.sv
hw/mul_rs.sv
hw/rob.sv
hw/ooo_core.sv
verification/tb_clock_gen.sv
verification/tb_ooo_core.sv
